// ==== Makefile ====
SIM := obj_dir/amul_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator from project.f and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module amul_tb \
		-Mdir obj_dir -o amul_sim
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== amul_cfg.svh ====
`ifndef AMUL_CFG_SVH
`define AMUL_CFG_SVH

//////////////////////////////
// approximation settings
//////////////////////////////

// OR-approximated low bits of the 6x6 merge adder
// (the adder inside the recursive high product)
`define AMUL_INNER_APPROX 2

// OR-approximated low bits of the 8x8 merge adder
`define AMUL_OUTER_APPROX 5

//////////////////////////////
// pipeline
//////////////////////////////

// input sample to out_valid, in rising edges:
// decode register, execute register, result register
`define AMUL_LATENCY 3

`endif

// ==== amul_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

// operand sign handling and 2/6 field split
module amul_decode (
    input  logic               signed_mode,
    input  logic [7:0]         a,
    input  logic [7:0]         b,
    output amul_pkg::dec_t     dec
);

    logic       a_neg;
    logic       b_neg;
    logic [7:0] a_mag;
    logic [7:0] b_mag;

    //////////////////////////////
    // magnitudes
    //////////////////////////////

    assign a_neg = signed_mode & a[7];
    assign b_neg = signed_mode & b[7];

    // -128 comes out as 8'h80, which is fine unsigned
    assign a_mag = a_neg ? (~a + 8'd1) : a;
    assign b_mag = b_neg ? (~b + 8'd1) : b;

    //////////////////////////////
    // field split
    //////////////////////////////

    always_comb begin
        dec.a_hi = a_mag[7:2];
        dec.b_hi = b_mag[7:2];
        dec.a_lo = a_mag[1:0];
        dec.b_lo = b_mag[1:0];
        // stays clear in unsigned mode
        dec.neg  = a_neg ^ b_neg;
    end

endmodule

`default_nettype wire

// ==== amul_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "amul_cfg.svh"

// partial products of the 2/6 split
// the 6x6 high product is built recursively from a 3/3 split
module amul_execute (
    input  amul_pkg::dec_t dec,
    output amul_pkg::exe_t exe
);

    logic [2:0]  a_hh;
    logic [2:0]  a_hl;
    logic [2:0]  b_hh;
    logic [2:0]  b_hl;
    logic [5:0]  q_hh;
    logic [5:0]  q_hl;
    logic [5:0]  q_lh;
    logic [5:0]  q_ll;
    logic [6:0]  q_cross;
    logic [9:0]  q_merge;

    //////////////////////////////
    // 6x6 via 3/3 split
    //////////////////////////////

    assign a_hh = dec.a_hi[5:3];
    assign a_hl = dec.a_hi[2:0];
    assign b_hh = dec.b_hi[5:3];
    assign b_hl = dec.b_hi[2:0];

    // all four 3x3 products are exact
    assign q_hh = {3'b000, a_hh} * {3'b000, b_hh};
    assign q_hl = {3'b000, a_hh} * {3'b000, b_hl};
    assign q_lh = {3'b000, a_hl} * {3'b000, b_hh};
    assign q_ll = {3'b000, a_hl} * {3'b000, b_hl};

    amul_loa_adder #(
        .width_a     (6),
        .width_b     (6),
        .approx_bits (0)
    ) i_inner_cross (
        .x   (q_hl),
        .y   (q_lh),
        .sum (q_cross)
    );

    // high product sits over the upper half of the low product
    amul_loa_adder #(
        .width_a     (9),
        .width_b     (7),
        .approx_bits (`AMUL_INNER_APPROX)
    ) i_inner_merge (
        .x   ({q_hh, q_ll[5:3]}),
        .y   (q_cross),
        .sum (q_merge)
    );

    //////////////////////////////
    // payload
    //////////////////////////////

    always_comb begin
        // top merge bit is always zero, a 6x6 product fits 12 bits
        exe.p_hh = {q_merge[8:0], q_ll[2:0]};
        exe.p_hl = {2'b00, dec.a_hi} * {6'b000000, dec.b_lo};
        exe.p_lh = {6'b000000, dec.a_lo} * {2'b00, dec.b_hi};
        exe.p_ll = {2'b00, dec.a_lo} * {2'b00, dec.b_lo};
        exe.neg  = dec.neg;
    end

endmodule

`default_nettype wire

// ==== amul_loa_adder.sv ====
`timescale 1ns/100ps
`default_nettype none

// lower-part OR adder
// low approx_bits of sum are x | y, the rest is an exact add
// with no carry in from the low part
module amul_loa_adder #(
    parameter int width_a     = 8,
    parameter int width_b     = 8,
    parameter int approx_bits = 0
) (
    input  logic [width_a-1:0] x,
    input  logic [width_b-1:0] y,
    output logic [width_a:0]   sum
);

    logic [width_a-1:0] y_ext;

    assign y_ext = width_a'(y);

    generate
        if (approx_bits == 0) begin : g_exact
            assign sum = {1'b0, x} + {1'b0, y_ext};
        end else begin : g_approx
            assign sum[approx_bits-1:0] = x[approx_bits-1:0] | y_ext[approx_bits-1:0];
            // carry out of the upper part is the top result bit
            assign sum[width_a:approx_bits] = {1'b0, x[width_a-1:approx_bits]}
                                            + {1'b0, y_ext[width_a-1:approx_bits]};
        end
    endgenerate

endmodule

`default_nettype wire

// ==== amul_pkg.sv ====
`default_nettype none

package amul_pkg;

    //////////////////////////////
    // decode -> execute
    //////////////////////////////

    // operand magnitudes split 6/2, the high field takes
    // the upper six bits of each magnitude
    typedef struct packed {
        logic [5:0] a_hi;
        logic [5:0] b_hi;
        logic [1:0] a_lo;
        logic [1:0] b_lo;
        // result is negated in the result stage
        logic       neg;
    } dec_t;

    //////////////////////////////
    // execute -> result
    //////////////////////////////

    // partial products of the 2/6 split
    //   p_hh  a_hi x b_hi, approximate (recursive 3/3)
    //   p_hl  a_hi x b_lo, exact
    //   p_lh  a_lo x b_hi, exact
    //   p_ll  a_lo x b_lo, exact
    typedef struct packed {
        logic [11:0] p_hh;
        logic [7:0]  p_hl;
        logic [7:0]  p_lh;
        logic [3:0]  p_ll;
        logic        neg;
    } exe_t;

endpackage

`default_nettype wire

// ==== amul_result.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "amul_cfg.svh"

// outer 8x8 merge, sign restore and output register
module amul_result (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  amul_pkg::exe_t exe,
    output logic           out_valid,
    output logic [15:0]    product
);

    logic [8:0]  cross_sum;
    logic [14:0] merge_sum;
    logic [15:0] mag;
    logic [15:0] res;

    //////////////////////////////
    // merge
    //////////////////////////////

    amul_loa_adder #(
        .width_a     (8),
        .width_b     (8),
        .approx_bits (0)
    ) i_outer_cross (
        .x   (exe.p_hl),
        .y   (exe.p_lh),
        .sum (cross_sum)
    );

    amul_loa_adder #(
        .width_a     (14),
        .width_b     (9),
        .approx_bits (`AMUL_OUTER_APPROX)
    ) i_outer_merge (
        .x   ({exe.p_hh, exe.p_ll[3:2]}),
        .y   (cross_sum),
        .sum (merge_sum)
    );

    // low two bits of the 2x2 product pass straight to the bottom
    assign mag = {merge_sum[13:0], exe.p_ll[1:0]};
    assign res = exe.neg ? (~mag + 16'd1) : mag;

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            product   <= 16'd0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                product <= res;
            end
        end
    end

endmodule

`default_nettype wire

// ==== amul_stage_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

// pipeline register with a valid bit beside the payload
module amul_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload holds on idle cycles
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== amul_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "amul_cfg.svh"

// concurrent checks on the top level ports
module amul_sva (
    input logic        clk,
    input logic        arst_n,
    input logic        in_valid,
    input logic        out_valid,
    input logic [15:0] product
);

    property p_quiet_in_reset;
        @(posedge clk) !arst_n |-> !out_valid;
    endproperty

    // fixed latency, gaps in in_valid come out as the same gaps
    property p_latency;
        @(posedge clk) disable iff (!arst_n)
            out_valid == $past(in_valid, `AMUL_LATENCY);
    endproperty

    property p_product_known;
        @(posedge clk) disable iff (!arst_n)
            out_valid |-> !$isunknown(product);
    endproperty

    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else $error("out_valid high while reset is held");
    a_latency: assert property (p_latency)
        else $error("out_valid does not follow in_valid by the pipeline latency");
    a_product_known: assert property (p_product_known)
        else $error("product has unknown bits while out_valid is high");

endmodule

bind amul_top amul_sva i_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .product   (product)
);

`default_nettype wire

// ==== amul_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "amul_cfg.svh"

module amul_tb;

    localparam real clk_period  = 8.0;
    localparam int  n_dir       = 13;
    localparam int  n_rand      = 2000;
    // a random item takes one issue cycle and up to two gap cycles
    localparam int  max_cycles  = 8 + 16 + n_dir + 2 * 3 * n_rand
                                  + 4 * (`AMUL_LATENCY + 4) + 200;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        signed_mode;
    logic [7:0]  a;
    logic [7:0]  b;
    logic        out_valid;
    logic [15:0] product;

    logic [15:0] exp_q[$];
    int          due_q[$];
    int          bound_q[$];
    int          cycle;
    int          seed;
    int          errors;
    int          n_checks;
    int          n_tests;
    int          bound;
    int          e0;
    int          c0;
    int          gap;
    logic [31:0] r;

    tb_clock #(.period(clk_period)) i_clock (.clk(clk));

    amul_top i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .signed_mode (signed_mode),
        .a           (a),
        .b           (b),
        .out_valid   (out_valid),
        .product     (product)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    // OR on the low k bits and an exact sum above them with no carry in
    function automatic int loa(input int x, input int y, input int k);
        int mask;
        mask = (1 << k) - 1;
        return ((((x >> k) + (y >> k)) << k) | ((x | y) & mask));
    endfunction

    function automatic logic [15:0] ref_product(input logic sm, input logic [7:0] x,
                                                input logic [7:0] y);
        int   xm, ym, xh, xl, yh, yl;
        int   hh, hl, lh, ll, p66, pll, cross_pp, merge, mag;
        logic neg;
        xm = (sm && x[7]) ? 256 - int'(x) : int'(x);
        ym = (sm && y[7]) ? 256 - int'(y) : int'(y);
        neg = sm && (x[7] ^ y[7]);
        xh = xm >> 2;
        xl = xm & 3;
        yh = ym >> 2;
        yl = ym & 3;
        // 6x6 from 3/3 fields
        hh = (xh >> 3) * (yh >> 3);
        hl = (xh >> 3) * (yh & 7);
        lh = (xh & 7) * (yh >> 3);
        ll = (xh & 7) * (yh & 7);
        p66 = ((loa(hh * 8 + (ll >> 3), hl + lh, `AMUL_INNER_APPROX) << 3) | (ll & 7)) & 'hfff;
        pll = xl * yl;
        cross_pp = xh * yl + xl * yh;
        merge = loa(p66 * 4 + (pll >> 2), cross_pp, `AMUL_OUTER_APPROX);
        mag = (merge * 4 + (pll & 3)) & 'hffff;
        return neg ? 16'(-mag) : 16'(mag);
    endfunction

    //////////////////////////////
    // stimulus and checking
    //////////////////////////////

    task automatic expect_eq(input string name, input int expected, input int actual);
        n_checks++;
        if (expected != actual) begin
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic issue(input logic sm, input logic [7:0] x, input logic [7:0] y);
        @(posedge clk);
        #1;
        in_valid    = 1'b1;
        signed_mode = sm;
        a           = x;
        b           = y;
        exp_q.push_back(ref_product(sm, x, y));
        due_q.push_back(cycle + `AMUL_LATENCY);
        bound_q.push_back(sm ? -1 : int'(x) * int'(y));
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (due_q.size() != 0) begin
            idle();
        end
    endtask

    task automatic close_test(input string name);
        drain();
        n_tests++;
        $display("test %-16s %0d checks, %0d errors", name, n_checks - c0, errors - e0);
        c0 = n_checks;
        e0 = errors;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs sampled at the falling edge while the registers are stable
    always @(negedge clk) begin
        if (arst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid high at %0t with no input pending", $time);
                    errors++;
                end else begin
                    expect_eq("out_valid", due_q.pop_front(), cycle);
                    expect_eq("product", int'(exp_q.pop_front()), int'(product));
                    bound = bound_q.pop_front();
                    n_checks++;
                    if (bound >= 0 && int'(product) > bound) begin
                        $display("[FAIL] %0t product %0d above exact product %0d",
                                 $time, product, bound);
                        errors++;
                    end
                end
            end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
                $display("out_valid missing at %0t for a result due in cycle %0d",
                         $time, due_q[0]);
                errors++;
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
                void'(bound_q.pop_front());
            end
        end
    end

    initial begin
        #(max_cycles * clk_period);
        $display("watchdog: run did not end within %0d cycles", max_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        signed_mode = 1'b0;
        a           = 8'd0;
        b           = 8'd0;
        cycle       = 0;
        seed        = 41169;
        errors      = 0;
        n_checks    = 0;
        n_tests     = 0;
        c0          = 0;
        e0          = 0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        repeat (16) idle();
        expect_eq("product", 0, int'(product));
        close_test("reset_idle");

        // corner operands issued back to back
        issue(1'b0, 8'd0, 8'd0);
        issue(1'b0, 8'd0, 8'd255);
        issue(1'b0, 8'd255, 8'd0);
        issue(1'b0, 8'd255, 8'd255);
        issue(1'b0, 8'd1, 8'd1);
        issue(1'b0, 8'd1, 8'd200);
        issue(1'b0, 8'd100, 8'd1);
        issue(1'b0, 8'd4, 8'd8);
        issue(1'b0, 8'd252, 8'd252);
        issue(1'b0, 8'd128, 8'd128);
        issue(1'b0, 8'd12, 8'd60);
        issue(1'b0, 8'd255, 8'd1);
        issue(1'b0, 8'd64, 8'd192);
        close_test("directed");

        for (int i = 0; i < n_rand; i++) begin
            r = $random(seed);
            issue(1'b0, r[7:0], r[15:8]);
            gap = (r[26:25] == 2'd0) ? int'(r[27]) + 1 : 0;
            repeat (gap) idle();
        end
        close_test("random_unsigned");

        for (int i = 0; i < n_rand; i++) begin
            r = $random(seed);
            // pull in -128 now and then
            issue(1'b1, (r[19:16] == 4'd0) ? 8'h80 : r[7:0],
                  (r[23:20] == 4'd0) ? 8'h80 : r[15:8]);
            gap = (r[26:25] == 2'd0) ? int'(r[27]) + 1 : 0;
            repeat (gap) idle();
        end
        close_test("random_signed");

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== amul_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// approximate 8x8 multiplier, decode / execute / result pipeline
module amul_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic        signed_mode,
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic        out_valid,
    output logic [15:0] product
);

    import amul_pkg::*;

    dec_t dec_d;
    dec_t dec_q;
    logic dec_valid;
    exe_t exe_d;
    exe_t exe_q;
    logic exe_valid;

    amul_decode i_decode (
        .signed_mode (signed_mode),
        .a           (a),
        .b           (b),
        .dec         (dec_d)
    );

    amul_stage_reg #(.payload_t(dec_t)) i_dec_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (dec_d),
        .out_valid (dec_valid),
        .out_data  (dec_q)
    );

    amul_execute i_execute (
        .dec (dec_q),
        .exe (exe_d)
    );

    amul_stage_reg #(.payload_t(exe_t)) i_exe_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (dec_valid),
        .in_data   (exe_d),
        .out_valid (exe_valid),
        .out_data  (exe_q)
    );

    amul_result i_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (exe_valid),
        .exe       (exe_q),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
amul_pkg.sv
amul_stage_reg.sv
amul_loa_adder.sv
amul_decode.sv
amul_execute.sv
amul_result.sv
amul_top.sv
amul_sva.sv
tb_clock.sv
amul_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

// free running testbench clock
module tb_clock #(
    parameter real period = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
